// File: router_pkg.sv
// shared types and sizes for the 2D mesh VC router
// import with router_pkg::* in the module header where needed

package router_pkg;

  // ==============================
  // port directions
  // ==============================

  // also the index of each port in all per-port arrays
  typedef enum logic [2:0] {
    NORTH = 3'd0,
    EAST  = 3'd1,
    SOUTH = 3'd2,
    WEST  = 3'd3,
    LOCAL = 3'd4
  } port_e;

  localparam int NUM_PORTS = 5;

  // ==============================
  // default sizes
  // ==============================

  localparam int COORD_W      = 4;
  localparam int DEF_NUM_VC   = 2;
  localparam int DEF_VC_DEPTH = 2;
  localparam int VC_W         = (DEF_NUM_VC > 1) ? $clog2(DEF_NUM_VC) : 1;
  localparam int PAYLOAD_W    = 16;

  // ==============================
  // link structs
  // ==============================

  typedef struct packed {
    logic [COORD_W-1:0] dst_x;
    logic [COORD_W-1:0] dst_y;
    logic               last;
    logic [VC_W-1:0]    vc;
  } flit_hdr_t;

  typedef struct packed {
    flit_hdr_t            hdr;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // data toward the next router
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  // one freed buffer slot, back toward the sender
  typedef struct packed {
    logic            valid;
    logic [VC_W-1:0] vc;
  } credit_t;

endpackage

// File: vc_input_port.sv
// input stage of one router port
// buffers incoming flits per VC, routes the VC heads with XY order,
// picks one VC by round-robin for switch allocation and returns credits
`timescale 1ns/1ns

module vc_input_port import router_pkg::*; #(
  parameter int NUM_VC   = DEF_NUM_VC,
  parameter int VC_DEPTH = DEF_VC_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [COORD_W-1:0]   my_x_i,
  input  logic [COORD_W-1:0]   my_y_i,
  input  link_t                in_link_i,
  output credit_t              up_credit_o,
  output logic [NUM_PORTS-1:0] req_dir_o,
  output logic                 req_last_o,
  output flit_t                head_flit_o,
  input  logic                 sent_i
);

  localparam int PTR_W = (VC_DEPTH > 1) ? $clog2(VC_DEPTH) : 1;
  localparam int CNT_W = $clog2(VC_DEPTH + 1);

  flit_t [NUM_VC-1:0] vc_head;
  logic  [NUM_VC-1:0] vc_valid;
  port_e [NUM_VC-1:0] vc_dir;

  logic [VC_W-1:0] rr_ptr_q;
  logic            hold_q;
  logic [VC_W-1:0] hold_vc_q;
  logic [VC_W-1:0] pick_vc;
  logic [VC_W-1:0] sel_vc;
  logic            sel_valid;
  logic            credit_valid_q;
  logic [VC_W-1:0] credit_vc_q;

  // X first, then Y; north is increasing y
  function automatic port_e xy_route(input flit_hdr_t hdr,
                                     input logic [COORD_W-1:0] x,
                                     input logic [COORD_W-1:0] y);
    port_e dir;
    if (hdr.dst_x > x) begin
      dir = EAST;
    end else if (hdr.dst_x < x) begin
      dir = WEST;
    end else if (hdr.dst_y > y) begin
      dir = NORTH;
    end else if (hdr.dst_y < y) begin
      dir = SOUTH;
    end else begin
      dir = LOCAL;
    end
    return dir;
  endfunction

  // ==============================
  // per-VC circular FIFOs
  // ==============================

  for (genvar v = 0; v < NUM_VC; v++) begin : gen_vc
    flit_t            mem [VC_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign push = in_link_i.valid && (in_link_i.flit.hdr.vc == VC_W'(v));
    assign pop  = sent_i && (sel_vc == VC_W'(v));

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem[wr_ptr_q] <= in_link_i.flit;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(VC_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(VC_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
    end

    assign vc_head[v]  = mem[rd_ptr_q];
    assign vc_valid[v] = (count_q != '0);
    assign vc_dir[v]   = xy_route(mem[rd_ptr_q].hdr, my_x_i, my_y_i);
  end

  // ==============================
  // local switch allocation
  // ==============================

  // first non-empty VC at or after the pointer
  always_comb begin
    int idx;
    idx     = 0;
    pick_vc = rr_ptr_q;
    for (int i = NUM_VC - 1; i >= 0; i--) begin
      idx = int'(rr_ptr_q) + i;
      if (idx >= NUM_VC) begin
        idx = idx - NUM_VC;
      end
      if (vc_valid[idx]) begin
        pick_vc = VC_W'(idx);
      end
    end
  end

  // a started packet keeps its VC until the last flit leaves
  assign sel_vc    = hold_q ? hold_vc_q : pick_vc;
  assign sel_valid = vc_valid[sel_vc];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_q    <= 1'b0;
      hold_vc_q <= '0;
      rr_ptr_q  <= '0;
    end else if (sent_i && req_last_o) begin
      hold_q   <= 1'b0;
      rr_ptr_q <= (sel_vc == VC_W'(NUM_VC - 1)) ? '0 : sel_vc + 1'b1;
    end else if (sel_valid) begin
      hold_q    <= 1'b1;
      hold_vc_q <= sel_vc;
    end
  end

  always_comb begin
    req_dir_o = '0;
    if (sel_valid) begin
      req_dir_o[vc_dir[sel_vc]] = 1'b1;
    end
  end

  assign req_last_o  = vc_head[sel_vc].hdr.last;
  assign head_flit_o = vc_head[sel_vc];

  // ==============================
  // upstream credit return
  // ==============================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_valid_q <= 1'b0;
    end else begin
      credit_valid_q <= sent_i;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_vc_q <= sel_vc;
  end

  assign up_credit_o = '{valid: credit_valid_q, vc: credit_vc_q};

endmodule

// File: output_allocator.sv
// switch allocation for one output port
// round-robin over the five inputs, downstream credit counting,
// VC choice for new packets and the wormhole lock
`timescale 1ns/1ns

module output_allocator import router_pkg::*; #(
  parameter int NUM_VC   = DEF_NUM_VC,
  parameter int VC_DEPTH = DEF_VC_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [NUM_PORTS-1:0] req_i,
  input  logic [NUM_PORTS-1:0] req_last_i,
  input  credit_t              down_credit_i,
  output logic [NUM_PORTS-1:0] grant_o,
  output logic [VC_W-1:0]      out_vc_o
);

  localparam int CNT_W = $clog2(VC_DEPTH + 1);
  localparam int IN_W  = $clog2(NUM_PORTS);

  logic [NUM_VC-1:0] vc_has_credit;
  logic              free_found;
  logic [VC_W-1:0]   free_vc;

  logic [IN_W-1:0]   rr_ptr_q;
  logic [IN_W-1:0]   rr_idx;
  logic              rr_found;

  logic              lock_q;
  logic [IN_W-1:0]   lock_in_q;
  logic [VC_W-1:0]   lock_vc_q;

  logic [IN_W-1:0]   gnt_idx;
  logic              gnt_valid;
  logic              gnt_last;

  // ==============================
  // downstream credit counters
  // ==============================

  for (genvar v = 0; v < NUM_VC; v++) begin : gen_credit
    logic [CNT_W-1:0] count_q;
    logic             inc;
    logic             dec;

    assign inc = down_credit_i.valid && (down_credit_i.vc == VC_W'(v));
    assign dec = gnt_valid && (out_vc_o == VC_W'(v));

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        count_q <= CNT_W'(VC_DEPTH);
      end else begin
        count_q <= count_q + CNT_W'(inc) - CNT_W'(dec);
      end
    end

    assign vc_has_credit[v] = (count_q != '0);
  end

  // lowest VC with a free slot takes the next packet
  always_comb begin
    free_found = 1'b0;
    free_vc    = '0;
    for (int v = NUM_VC - 1; v >= 0; v--) begin
      if (vc_has_credit[v]) begin
        free_found = 1'b1;
        free_vc    = VC_W'(v);
      end
    end
  end

  // ==============================
  // global round-robin arbiter
  // ==============================

  always_comb begin
    int idx;
    idx      = 0;
    rr_found = 1'b0;
    rr_idx   = rr_ptr_q;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      idx = int'(rr_ptr_q) + i;
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      if (req_i[idx]) begin
        rr_found = 1'b1;
        rr_idx   = IN_W'(idx);
      end
    end
  end

  // locked output serves only the packet in flight
  always_comb begin
    if (lock_q) begin
      gnt_idx   = lock_in_q;
      out_vc_o  = lock_vc_q;
      gnt_valid = req_i[lock_in_q] && vc_has_credit[lock_vc_q];
    end else begin
      gnt_idx   = rr_idx;
      out_vc_o  = free_vc;
      gnt_valid = rr_found && free_found;
    end
  end

  assign gnt_last = req_last_i[gnt_idx];

  always_comb begin
    grant_o = '0;
    if (gnt_valid) begin
      grant_o[gnt_idx] = 1'b1;
    end
  end

  // ==============================
  // wormhole lock
  // ==============================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q    <= 1'b0;
      lock_in_q <= '0;
      lock_vc_q <= '0;
      rr_ptr_q  <= '0;
    end else if (gnt_valid) begin
      lock_q    <= !gnt_last;
      lock_in_q <= gnt_idx;
      lock_vc_q <= out_vc_o;
      // pointer only moves once a packet is complete
      if (gnt_last) begin
        rr_ptr_q <= (gnt_idx == IN_W'(NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

endmodule

// File: switch_traversal.sv
// crossbar and output registers of the router
// selects the granted head flit per output, sets the downstream VC
// and holds it for one cycle on the output link
`timescale 1ns/1ns

module switch_traversal import router_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // [output][input]
  input  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_i,
  input  logic [NUM_PORTS-1:0][VC_W-1:0]      out_vc_i,
  input  flit_t [NUM_PORTS-1:0]               head_flit_i,
  output link_t [NUM_PORTS-1:0]               out_link_o
);

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    flit_t sel_flit;
    flit_t flit_q;
    logic  valid_q;

    // one-hot and-or mux over the inputs
    always_comb begin
      sel_flit = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (grant_i[o][i]) begin
          sel_flit = flit_t'(sel_flit | head_flit_i[i]);
        end
      end
      sel_flit.hdr.vc = out_vc_i[o];
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= |grant_i[o];
      end
    end

    always_ff @(posedge clk_i) begin
      if (|grant_i[o]) begin
        flit_q <= sel_flit;
      end
    end

    assign out_link_o[o] = '{valid: valid_q, flit: flit_q};
  end

endmodule

// File: vc_router.sv
// five-port wormhole router with virtual channels for a 2D mesh
// ports follow port_e order, N E S W then local
// my_x_i and my_y_i strap the router position in the mesh
`timescale 1ns/1ns

module vc_router import router_pkg::*; #(
  parameter int NUM_VC   = DEF_NUM_VC,
  parameter int VC_DEPTH = DEF_VC_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [COORD_W-1:0]     my_x_i,
  input  logic [COORD_W-1:0]     my_y_i,
  input  link_t [NUM_PORTS-1:0]   in_link_i,
  output credit_t [NUM_PORTS-1:0] up_credit_o,
  output link_t [NUM_PORTS-1:0]   out_link_o,
  input  credit_t [NUM_PORTS-1:0] down_credit_i
);

  // input space, [input][output]
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_dir;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_t;
  logic [NUM_PORTS-1:0]                req_last;
  logic [NUM_PORTS-1:0]                sent;
  flit_t [NUM_PORTS-1:0]               head_flit;

  // output space, [output][input]
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] out_req;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;
  logic [NUM_PORTS-1:0][VC_W-1:0]      out_vc;

  // ==============================
  // input ports
  // ==============================

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
    vc_input_port #(
      .NUM_VC   (NUM_VC),
      .VC_DEPTH (VC_DEPTH)
    ) u_in_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .in_link_i   (in_link_i[i]),
      .up_credit_o (up_credit_o[i]),
      .req_dir_o   (req_dir[i]),
      .req_last_o  (req_last[i]),
      .head_flit_o (head_flit[i]),
      .sent_i      (sent[i])
    );
  end

  // ==============================
  // input/output transposes
  // ==============================

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_tr_in
    for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_tr_out
      assign out_req[o][i] = req_dir[i][o];
      assign grant_t[i][o] = grant[o][i];
    end
    // at most one output grants a given input
    assign sent[i] = |grant_t[i];
  end

  // ==============================
  // output allocators
  // ==============================

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    output_allocator #(
      .NUM_VC   (NUM_VC),
      .VC_DEPTH (VC_DEPTH)
    ) u_alloc (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_i         (out_req[o]),
      .req_last_i    (req_last),
      .down_credit_i (down_credit_i[o]),
      .grant_o       (grant[o]),
      .out_vc_o      (out_vc[o])
    );
  end

  switch_traversal u_switch (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .grant_i     (grant),
    .out_vc_i    (out_vc),
    .head_flit_i (head_flit),
    .out_link_o  (out_link_o)
  );

endmodule

// File: vc_router_assert.sv
// protocol assertions for the router
// bound into vc_router at the end of this file
`timescale 1ns/1ns

module vc_router_assert import router_pkg::*; (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input link_t [NUM_PORTS-1:0]               in_link_i,
  input link_t [NUM_PORTS-1:0]               out_link_i,
  input credit_t [NUM_PORTS-1:0]             up_credit_i,
  input logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_i,
  input logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_i
);

  logic                 rst_seen_q;
  logic                 in_seen_q;
  logic [NUM_PORTS-1:0] in_valid;
  logic [NUM_PORTS-1:0] out_valid;
  logic [NUM_PORTS-1:0] cr_valid;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_valid
    assign in_valid[p]  = in_link_i[p].valid;
    assign out_valid[p] = out_link_i[p].valid;
    assign cr_valid[p]  = up_credit_i[p].valid;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_seen_q <= 1'b1;
    end
  end

  // sticky, set once any input flit was sampled
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_seen_q <= 1'b0;
    end else if (|in_valid) begin
      in_seen_q <= 1'b1;
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk_i)
    rst_seen_q && !$past(rst_n_i) |-> !(|out_valid) && !(|cr_valid))
    else $error("output or credit valid during reset");

  a_no_early_output: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |out_valid |-> $past(in_seen_q))
    else $error("output flit earlier than two edges after input");

  // grant goes to at most one input, and only to one that requests
  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_grant
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(grant_i[o]) && ((grant_i[o] & ~req_i[o]) == '0))
      else $error("allocator grant is not one-hot or goes to an idle input");
  end

endmodule

bind vc_router vc_router_assert u_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_link_i   (in_link_i),
  .out_link_i  (out_link_o),
  .up_credit_i (up_credit_o),
  .req_i       (out_req),
  .grant_i     (grant)
);

// File: vc_router_checker.sv
// scoreboard for the router testbench
// queues every input flit per source port and VC, then matches output
// flits against them, checks XY ports, packet contiguity and credits
`timescale 1ns/1ns

module vc_router_checker import router_pkg::*; #(
  parameter int NUM_VC   = DEF_NUM_VC,
  parameter int VC_DEPTH = DEF_VC_DEPTH,
  parameter int POS_X    = 2,
  parameter int POS_Y    = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  link_t [NUM_PORTS-1:0]   in_link_i,
  input  credit_t [NUM_PORTS-1:0] up_credit_i,
  input  link_t [NUM_PORTS-1:0]   out_link_i,
  input  credit_t [NUM_PORTS-1:0] down_credit_i,
  input  logic                    final_i,
  output int                      pending_o,
  output logic                    final_done_o,
  output int                      route_err_o,
  output int                      order_err_o,
  output int                      flow_err_o,
  output int                      credit_err_o
);

  flit_t           exp_q [NUM_PORTS*NUM_VC][$];
  int              down_cnt [NUM_PORTS][NUM_VC];
  int              in_cnt [NUM_PORTS][NUM_VC];
  int              cred_cnt [NUM_PORTS][NUM_VC];
  logic            pkt_open [NUM_PORTS];
  int              pkt_key [NUM_PORTS];
  logic [VC_W-1:0] pkt_vc [NUM_PORTS];

  // dimension order, x then y, north is larger y
  function automatic int expected_port(input int dx, input int dy);
    int port;
    if (dx < POS_X) begin
      port = int'(WEST);
    end else if (dx > POS_X) begin
      port = int'(EAST);
    end else if (dy < POS_Y) begin
      port = int'(SOUTH);
    end else if (dy > POS_Y) begin
      port = int'(NORTH);
    end else begin
      port = int'(LOCAL);
    end
    return port;
  endfunction

  initial begin
    pending_o    = 0;
    final_done_o = 1'b0;
    route_err_o  = 0;
    order_err_o  = 0;
    flow_err_o   = 0;
    credit_err_o = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      pkt_open[p] = 1'b0;
      pkt_key[p]  = 0;
      pkt_vc[p]   = '0;
      for (int v = 0; v < NUM_VC; v++) begin
        down_cnt[p][v] = VC_DEPTH;
        in_cnt[p][v]   = 0;
        cred_cnt[p][v] = 0;
      end
    end
  end

  // ==============================
  // sampling at the falling edge
  // ==============================

  always @(negedge clk_i) begin
    flit_t got;
    flit_t exp;
    int    key;
    int    port;
    if (rst_n_i && !final_done_o) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (in_link_i[p].valid) begin
          exp_q[p*NUM_VC + int'(in_link_i[p].flit.hdr.vc)].push_back(in_link_i[p].flit);
          in_cnt[p][in_link_i[p].flit.hdr.vc]++;
          pending_o++;
        end
        if (up_credit_i[p].valid) begin
          cred_cnt[p][up_credit_i[p].vc]++;
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (out_link_i[o].valid) begin
          got = out_link_i[o].flit;
          // payload is {source port, source vc, sequence}
          key = int'(got.payload[15:13]) * NUM_VC + int'(got.payload[12]);
          if (got.payload[15:13] >= NUM_PORTS || exp_q[key].size() == 0) begin
            $display("unexpected flit on output %0d, payload 0x%0h was never sent",
                     o, got.payload);
            order_err_o++;
          end else begin
            exp = exp_q[key].pop_front();
            pending_o--;
            if ({got.hdr.dst_x, got.hdr.dst_y, got.hdr.last, got.payload} !=
                {exp.hdr.dst_x, exp.hdr.dst_y, exp.hdr.last, exp.payload}) begin
              $display("ERROR: out_link_o[%0d].flit 0x%0h expected 0x%0h", o, got, exp);
              order_err_o++;
            end
            port = expected_port(int'(exp.hdr.dst_x), int'(exp.hdr.dst_y));
            if (port != o) begin
              $display("ERROR: out_link_o port 0x%0h expected 0x%0h", o, port);
              route_err_o++;
            end
          end
          // one packet at a time per output
          if (pkt_open[o] && (key != pkt_key[o] || got.hdr.vc != pkt_vc[o])) begin
            $display("ERROR: out_link_o[%0d] source/vc 0x%0h expected 0x%0h",
                     o, {key, got.hdr.vc}, {pkt_key[o], pkt_vc[o]});
            order_err_o++;
          end
          pkt_open[o] = !got.hdr.last;
          pkt_key[o]  = key;
          pkt_vc[o]   = got.hdr.vc;
          if (down_cnt[o][got.hdr.vc] == 0) begin
            $display("credit overrun on output %0d vc %0d, sent without a credit",
                     o, got.hdr.vc);
            flow_err_o++;
          end else begin
            down_cnt[o][got.hdr.vc]--;
          end
        end
        // credit of this edge counts from the next grant on
        if (down_credit_i[o].valid) begin
          down_cnt[o][down_credit_i[o].vc]++;
        end
      end
      if (final_i) begin
        for (int k = 0; k < NUM_PORTS*NUM_VC; k++) begin
          if (exp_q[k].size() != 0) begin
            $display("missing %0d flits from input %0d vc %0d at end of run",
                     exp_q[k].size(), k / NUM_VC, k % NUM_VC);
            order_err_o++;
          end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
          for (int v = 0; v < NUM_VC; v++) begin
            if (cred_cnt[p][v] != in_cnt[p][v]) begin
              $display("ERROR: up_credit_o[%0d] vc %0d count 0x%0h expected 0x%0h",
                       p, v, cred_cnt[p][v], in_cnt[p][v]);
              credit_err_o++;
            end
          end
        end
        final_done_o = 1'b1;
      end
    end
  end

endmodule

// File: vc_router_tb.sv
// testbench for the VC router at mesh position (2,2)
// random packets on all five inputs under upstream credit control,
// delayed downstream credits with stalls, checked by vc_router_checker
`timescale 1ns/1ns

module vc_router_tb import router_pkg::*; ();

  localparam int NUM_VC   = DEF_NUM_VC;
  localparam int VC_DEPTH = DEF_VC_DEPTH;
  localparam int NUM_PKTS = 300;
  localparam int POS      = 2;

  logic                    clk;
  logic                    rst_n;
  logic [COORD_W-1:0]      my_x;
  logic [COORD_W-1:0]      my_y;
  link_t [NUM_PORTS-1:0]   in_link;
  link_t [NUM_PORTS-1:0]   out_link;
  credit_t [NUM_PORTS-1:0] up_credit;
  credit_t [NUM_PORTS-1:0] down_credit;

  logic [31:0]        rng;
  int                 cycle;
  int                 rst_cycles;
  int                 flits_sent;
  int                 up_cred [NUM_PORTS][NUM_VC];
  int                 flits_left [NUM_PORTS];
  int                 pkts_sent [NUM_PORTS];
  int                 stall_cnt [NUM_PORTS];
  logic [COORD_W-1:0] cur_x [NUM_PORTS];
  logic [COORD_W-1:0] cur_y [NUM_PORTS];
  logic [VC_W-1:0]    cur_vc [NUM_PORTS];
  logic [11:0]        seq [NUM_PORTS][NUM_VC];
  int                 due_q [NUM_PORTS][$];
  logic [VC_W-1:0]    ret_vc_q [NUM_PORTS][$];
  logic               drained;
  logic               final_req;
  logic               final_done;
  int                 pending;
  int                 route_err;
  int                 order_err;
  int                 flow_err;
  int                 credit_err;

  vc_router #(
    .NUM_VC   (NUM_VC),
    .VC_DEPTH (VC_DEPTH)
  ) UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .my_x_i        (my_x),
    .my_y_i        (my_y),
    .in_link_i     (in_link),
    .up_credit_o   (up_credit),
    .out_link_o    (out_link),
    .down_credit_i (down_credit)
  );

  vc_router_checker #(
    .NUM_VC   (NUM_VC),
    .VC_DEPTH (VC_DEPTH),
    .POS_X    (POS),
    .POS_Y    (POS)
  ) u_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .in_link_i     (in_link),
    .up_credit_i   (up_credit),
    .out_link_i    (out_link),
    .down_credit_i (down_credit),
    .final_i       (final_req),
    .pending_o     (pending),
    .final_done_o  (final_done),
    .route_err_o   (route_err),
    .order_err_o   (order_err),
    .flow_err_o    (flow_err),
    .credit_err_o  (credit_err)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // output port that a destination takes from (2,2)
  function automatic int dest_port(input int dx, input int dy);
    if (dx != POS) begin
      return (dx > POS) ? int'(EAST) : int'(WEST);
    end
    if (dy != POS) begin
      return (dy > POS) ? int'(NORTH) : int'(SOUTH);
    end
    return int'(LOCAL);
  endfunction

  // new packet, never routed back out of its own port
  task automatic start_packet(input int p);
    int dx;
    int dy;
    do begin
      rng = xorshift(rng);
      dx  = int'(rng % 5);
      rng = xorshift(rng);
      dy  = int'(rng % 5);
    end while (dest_port(dx, dy) == p);
    rng = xorshift(rng);
    cur_x[p]      = COORD_W'(dx);
    cur_y[p]      = COORD_W'(dy);
    cur_vc[p]     = VC_W'(rng[4]);
    flits_left[p] = 1 + int'(rng[1:0]);
    pkts_sent[p]++;
  endtask

  // ==============================
  // stimulus, credits and timeout
  // ==============================

  always @(posedge clk) begin
    flit_t f;
    logic  done;
    cycle = cycle + 1;
    if (cycle > 40 * flits_sent + 500) begin
      $display("timeout after %0d cycles, router did not drain", cycle);
      $display("Test failures found");
      $finish;
    end else if (!rst_n) begin
      rst_cycles++;
      if (rst_cycles >= 10) begin
        rst_n <= 1'b1;
      end
    end else begin
      done = 1'b1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (up_credit[p].valid) begin
          up_cred[p][up_credit[p].vc]++;
        end
        in_link[p] <= '0;
        if (flits_left[p] == 0 && pkts_sent[p] < NUM_PKTS) begin
          start_packet(p);
        end
        rng = xorshift(rng);
        if (flits_left[p] > 0 && rng[1:0] != 2'd0 && up_cred[p][cur_vc[p]] > 0) begin
          f.hdr.dst_x = cur_x[p];
          f.hdr.dst_y = cur_y[p];
          f.hdr.last  = (flits_left[p] == 1);
          f.hdr.vc    = cur_vc[p];
          f.payload   = {3'(p), cur_vc[p], seq[p][cur_vc[p]]};
          in_link[p] <= '{valid: 1'b1, flit: f};
          seq[p][cur_vc[p]]++;
          up_cred[p][cur_vc[p]]--;
          flits_left[p]--;
          flits_sent++;
        end
        if (flits_left[p] != 0 || pkts_sent[p] < NUM_PKTS) begin
          done = 1'b0;
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        rng = xorshift(rng);
        if (out_link[o].valid) begin
          due_q[o].push_back(cycle + int'(rng % 6));
          ret_vc_q[o].push_back(out_link[o].flit.hdr.vc);
        end
        down_credit[o] <= '0;
        if (stall_cnt[o] > 0) begin
          stall_cnt[o]--;
        end else if (due_q[o].size() > 0 && due_q[o][0] <= cycle) begin
          down_credit[o] <= '{valid: 1'b1, vc: ret_vc_q[o][0]};
          void'(due_q[o].pop_front());
          void'(ret_vc_q[o].pop_front());
        end
        // back-pressure bursts
        if (cycle % 32 == 0 && rng[9:8] == 2'd0) begin
          stall_cnt[o] = 12;
        end
        if (due_q[o].size() != 0) begin
          done = 1'b0;
        end
      end
      drained = done && (pending == 0);
    end
  end

  // ==============================
  // main sequence
  // ==============================

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    my_x        = COORD_W'(POS);
    my_y        = COORD_W'(POS);
    in_link     = '0;
    down_credit = '0;
    rng         = 32'h75d3;
    cycle       = 0;
    rst_cycles  = 0;
    flits_sent  = 0;
    drained     = 1'b0;
    final_req   = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      flits_left[p] = 0;
      pkts_sent[p]  = 0;
      stall_cnt[p]  = 0;
      for (int v = 0; v < NUM_VC; v++) begin
        up_cred[p][v] = VC_DEPTH;
        seq[p][v]     = '0;
      end
    end
    wait (rst_n);
    wait (drained);
    repeat (5) @(posedge clk);
    final_req = 1'b1;
    wait (final_done);
    $display("errors: route=%0d order=%0d overrun=%0d credit=%0d flits=%0d",
             route_err, order_err, flow_err, credit_err, flits_sent);
    if (route_err + order_err + flow_err + credit_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: vc_router.f
router_pkg.sv
vc_input_port.sv
output_allocator.sv
switch_traversal.sv
vc_router.sv
vc_router_assert.sv
vc_router_checker.sv
vc_router_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vc_router_tb
FILELIST = vc_router.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
